// ==== logic/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath widths
`define XLEN          32
`define REG_IDX_W     5
`define ROB_IDX_W     4

// Data RAM and the one-line tag model
`define DMEM_WORDS    256
`define LINE_WORDS    4
`define REFILL_CYCLES 3

`endif

// ==== logic/cpu_types_pkg.sv ====
`default_nettype none

`include "cpu_settings.svh"

package cpu_types_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [2:0]            instr_class_t;

    // Instruction classes as delivered by issue
    localparam instr_class_t ALU    = 3'd0;
    localparam instr_class_t LOAD   = 3'd1;
    localparam instr_class_t STORE  = 3'd2;
    localparam instr_class_t BRANCH = 3'd3;
    // Writes pc+4 and always redirects
    localparam instr_class_t JUMP   = 3'd4;

endpackage

`default_nettype wire

// ==== logic/mem_ops_pkg.sv ====
`default_nettype none

package mem_ops_pkg;

    typedef logic [2:0] exc_code_t;

    // Same numbers as the RISC-V mcause values
    localparam exc_code_t EXC_NONE             = 3'd0;
    localparam exc_code_t EXC_LOAD_MISALIGNED  = 3'd4;
    localparam exc_code_t EXC_LOAD_FAULT       = 3'd5;
    localparam exc_code_t EXC_STORE_MISALIGNED = 3'd6;
    localparam exc_code_t EXC_STORE_FAULT      = 3'd7;

    // Data cache refill sequencing
    typedef enum logic {
        MEM_IDLE,
        MEM_REFILL
    } mem_state_t;

endpackage

`default_nettype wire

// ==== logic/ex_mem_if.sv ====
`default_nettype none

interface ex_mem_if;

    logic                         valid;
    cpu_types_pkg::word_t         alu_out;
    cpu_types_pkg::word_t         new_pc;
    logic                         branch_taken;
    cpu_types_pkg::word_t         store_data;
    cpu_types_pkg::reg_idx_t      rd;
    cpu_types_pkg::funct3_t       funct3;
    cpu_types_pkg::instr_class_t  iclass;
    cpu_types_pkg::rob_idx_t      rob_idx;
    logic                         wr_en;

    // Pipeline register side
    modport stage (
        output valid, alu_out, new_pc, branch_taken, store_data,
        output rd, funct3, iclass, rob_idx, wr_en
    );

    // Memory stage side
    modport mem (
        input valid, alu_out, new_pc, branch_taken, store_data,
        input rd, funct3, iclass, rob_idx, wr_en
    );

endinterface

`default_nettype wire

// ==== logic/exec_alu.sv ====
`default_nettype none

module exec_alu (
    input  wire cpu_types_pkg::word_t         op_a,
    input  wire cpu_types_pkg::word_t         op_b,
    input  wire cpu_types_pkg::word_t         pc,
    input  wire cpu_types_pkg::word_t         imm,
    input  wire cpu_types_pkg::funct3_t       funct3,
    input  wire                               alt_op,
    input  wire cpu_types_pkg::instr_class_t  iclass,
    output cpu_types_pkg::word_t              alu_out,
    output cpu_types_pkg::word_t              new_pc,
    output logic                              branch_taken
);

    cpu_types_pkg::word_t pc_plus4;
    cpu_types_pkg::word_t pc_target;
    cpu_types_pkg::word_t base_sum;
    cpu_types_pkg::word_t alu_res;
    logic                 cond;

    assign pc_plus4  = pc + cpu_types_pkg::word_t'(4);
    assign pc_target = pc + imm;
    assign base_sum  = op_a + imm;

    // Register-register operations
    always_comb begin
        case (funct3)
            3'b000:  alu_res = alt_op ? op_a - op_b : op_a + op_b;
            3'b001:  alu_res = op_a << op_b[4:0];
            3'b010:  alu_res = cpu_types_pkg::word_t'($signed(op_a) < $signed(op_b));
            3'b011:  alu_res = cpu_types_pkg::word_t'(op_a < op_b);
            3'b100:  alu_res = op_a ^ op_b;
            3'b101:  alu_res = alt_op ? cpu_types_pkg::word_t'($signed(op_a) >>> op_b[4:0])
                                      : op_a >> op_b[4:0];
            3'b110:  alu_res = op_a | op_b;
            default: alu_res = op_a & op_b;
        endcase
    end

    // Branch condition
    always_comb begin
        case (funct3)
            3'b000:  cond = (op_a == op_b);
            3'b001:  cond = (op_a != op_b);
            3'b100:  cond = ($signed(op_a) < $signed(op_b));
            3'b101:  cond = ($signed(op_a) >= $signed(op_b));
            3'b110:  cond = (op_a < op_b);
            3'b111:  cond = (op_a >= op_b);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        alu_out      = '0;
        new_pc       = pc_plus4;
        branch_taken = 1'b0;
        case (iclass)
            cpu_types_pkg::ALU: alu_out = alu_res;
            cpu_types_pkg::LOAD, cpu_types_pkg::STORE: alu_out = base_sum;
            cpu_types_pkg::BRANCH: begin
                branch_taken = cond;
                new_pc       = cond ? pc_target : pc_plus4;
            end
            cpu_types_pkg::JUMP: begin
                alu_out      = pc_plus4;
                new_pc       = base_sum & ~cpu_types_pkg::word_t'(1);
                branch_taken = 1'b1;
            end
            default: alu_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_mem_regs.sv ====
`default_nettype none

module ex_mem_regs (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               issue_valid,
    input  wire cpu_types_pkg::word_t         alu_out,
    input  wire cpu_types_pkg::word_t         new_pc,
    input  wire cpu_types_pkg::word_t         store_data,
    input  wire                               branch_taken,
    input  wire cpu_types_pkg::reg_idx_t      rd,
    input  wire cpu_types_pkg::funct3_t       funct3,
    input  wire cpu_types_pkg::instr_class_t  iclass,
    input  wire cpu_types_pkg::rob_idx_t      rob_idx,
    input  wire                               dcache_stall,
    ex_mem_if.stage                           exm
);

    logic wr_en_next;

    // x0 is never written
    always_comb begin
        case (iclass)
            cpu_types_pkg::ALU, cpu_types_pkg::LOAD, cpu_types_pkg::JUMP:
                wr_en_next = (rd != '0);
            default:
                wr_en_next = 1'b0;
        endcase
    end

    // Control fields, cleared by reset and by bubbles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exm.valid        <= 1'b0;
            exm.branch_taken <= 1'b0;
            exm.wr_en        <= 1'b0;
        end else if (!dcache_stall) begin
            exm.valid        <= issue_valid;
            exm.branch_taken <= issue_valid & branch_taken;
            exm.wr_en        <= issue_valid & wr_en_next;
        end
    end

    // Payload only moves with a real instruction
    always_ff @(posedge clk) begin
        if (issue_valid && !dcache_stall) begin
            exm.alu_out    <= alu_out;
            exm.new_pc     <= new_pc;
            exm.store_data <= store_data;
            exm.rd         <= rd;
            exm.funct3     <= funct3;
            exm.iclass     <= iclass;
            exm.rob_idx    <= rob_idx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`default_nettype none

`include "cpu_settings.svh"

module mem_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    ex_mem_if.mem                     exm,
    output logic                      dcache_stall,
    output logic                      complete,
    output cpu_types_pkg::rob_idx_t   complete_idx,
    output cpu_types_pkg::word_t      complete_value,
    output cpu_types_pkg::word_t      complete_pc,
    output logic                      complete_taken,
    output mem_ops_pkg::exc_code_t    complete_exc
);

    localparam int BYTES    = `XLEN / 8;
    localparam int IDX_W    = $clog2(`DMEM_WORDS);
    localparam int LINE_LSB = 2 + $clog2(`LINE_WORDS);
    localparam int CNT_W    = $clog2(`REFILL_CYCLES);

    cpu_types_pkg::word_t dmem [`DMEM_WORDS];

    logic                       is_load;
    logic                       is_store;
    logic                       misaligned;
    logic                       out_of_range;
    mem_ops_pkg::exc_code_t     exc;
    logic                       access;
    logic                       miss;
    logic                       finish;
    logic [1:0]                 byte_off;
    logic [IDX_W-1:0]           word_idx;
    logic [`XLEN-LINE_LSB-1:0]  line;
    logic [`XLEN-LINE_LSB-1:0]  line_tag;
    logic                       tag_valid;
    mem_ops_pkg::mem_state_t    state;
    logic [CNT_W-1:0]           refill_cnt;
    cpu_types_pkg::word_t       rshift;
    cpu_types_pkg::word_t       load_data;
    cpu_types_pkg::word_t       wdata;
    logic [BYTES-1:0]           lane_en;

    assign is_load  = exm.valid && (exm.iclass == cpu_types_pkg::LOAD);
    assign is_store = exm.valid && (exm.iclass == cpu_types_pkg::STORE);
    assign byte_off = exm.alu_out[1:0];
    assign word_idx = exm.alu_out[2 +: IDX_W];
    assign line     = exm.alu_out[`XLEN-1:LINE_LSB];

    assign out_of_range = (exm.alu_out >> 2) >= cpu_types_pkg::word_t'(`DMEM_WORDS);

    always_comb begin
        case (exm.funct3[1:0])
            2'b00:   misaligned = 1'b0;
            2'b01:   misaligned = byte_off[0];
            default: misaligned = (byte_off != 2'b00);
        endcase
    end

    // Misalignment wins over range
    always_comb begin
        exc = mem_ops_pkg::EXC_NONE;
        if (is_load) begin
            if (misaligned)        exc = mem_ops_pkg::EXC_LOAD_MISALIGNED;
            else if (out_of_range) exc = mem_ops_pkg::EXC_LOAD_FAULT;
        end else if (is_store) begin
            if (misaligned)        exc = mem_ops_pkg::EXC_STORE_MISALIGNED;
            else if (out_of_range) exc = mem_ops_pkg::EXC_STORE_FAULT;
        end
    end

    assign access       = (is_load || is_store) && (exc == mem_ops_pkg::EXC_NONE);
    assign miss         = !tag_valid || (line != line_tag);
    assign dcache_stall = (state == mem_ops_pkg::MEM_REFILL) || (access && miss);
    assign finish       = exm.valid && !dcache_stall;

    // Stall is already high in the miss cycle, the refill state covers the rest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= mem_ops_pkg::MEM_IDLE;
            refill_cnt <= '0;
            line_tag   <= '0;
            tag_valid  <= 1'b0;
        end else begin
            case (state)
                mem_ops_pkg::MEM_IDLE: begin
                    if (access && miss) begin
                        state      <= mem_ops_pkg::MEM_REFILL;
                        refill_cnt <= CNT_W'(1);
                    end
                end
                default: begin
                    if (refill_cnt == CNT_W'(`REFILL_CYCLES - 1)) begin
                        state     <= mem_ops_pkg::MEM_IDLE;
                        line_tag  <= line;
                        tag_valid <= 1'b1;
                    end else begin
                        refill_cnt <= refill_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Load extraction
    assign rshift = dmem[word_idx] >> {byte_off, 3'b000};

    always_comb begin
        case (exm.funct3)
            3'b000:  load_data = {{(`XLEN-8){rshift[7]}}, rshift[7:0]};
            3'b001:  load_data = {{(`XLEN-16){rshift[15]}}, rshift[15:0]};
            3'b100:  load_data = {{(`XLEN-8){1'b0}}, rshift[7:0]};
            3'b101:  load_data = {{(`XLEN-16){1'b0}}, rshift[15:0]};
            default: load_data = rshift;
        endcase
    end

    // Store lanes
    assign wdata = exm.store_data << {byte_off, 3'b000};

    always_comb begin
        case (exm.funct3[1:0])
            2'b00:   lane_en = BYTES'(1) << byte_off;
            2'b01:   lane_en = BYTES'(3) << byte_off;
            default: lane_en = '1;
        endcase
    end

    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (finish && access && is_store) begin
            for (int b = 0; b < BYTES; b++) begin
                if (lane_en[b]) begin
                    dmem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // ROB completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            complete       <= 1'b0;
            complete_taken <= 1'b0;
            complete_exc   <= mem_ops_pkg::EXC_NONE;
        end else begin
            complete       <= finish;
            complete_taken <= finish & exm.branch_taken;
            complete_exc   <= finish ? exc : mem_ops_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            complete_idx <= exm.rob_idx;
            complete_pc  <= exm.new_pc;
            if (exc != mem_ops_pkg::EXC_NONE) begin
                complete_value <= '0;
            end else if (is_load) begin
                complete_value <= load_data;
            end else begin
                complete_value <= exm.alu_out;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_mem_top.sv ====
`default_nettype none

module ex_mem_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               issue_valid,
    input  wire cpu_types_pkg::word_t         op_a,
    input  wire cpu_types_pkg::word_t         op_b,
    input  wire cpu_types_pkg::word_t         pc,
    input  wire cpu_types_pkg::word_t         imm,
    input  wire cpu_types_pkg::word_t         store_data,
    input  wire cpu_types_pkg::funct3_t       funct3,
    input  wire                               alt_op,
    input  wire cpu_types_pkg::instr_class_t  iclass,
    input  wire cpu_types_pkg::reg_idx_t      rd,
    input  wire cpu_types_pkg::rob_idx_t      rob_idx,
    output wire                               stall,
    output wire                               complete,
    output wire cpu_types_pkg::rob_idx_t      complete_idx,
    output wire cpu_types_pkg::word_t         complete_value,
    output wire cpu_types_pkg::word_t         complete_pc,
    output wire                               complete_taken,
    output wire mem_ops_pkg::exc_code_t       complete_exc
);

    cpu_types_pkg::word_t alu_out;
    cpu_types_pkg::word_t new_pc;
    logic                 branch_taken;

    ex_mem_if exm ();

    exec_alu i_alu (
        .op_a         (op_a),
        .op_b         (op_b),
        .pc           (pc),
        .imm          (imm),
        .funct3       (funct3),
        .alt_op       (alt_op),
        .iclass       (iclass),
        .alu_out      (alu_out),
        .new_pc       (new_pc),
        .branch_taken (branch_taken)
    );

    ex_mem_regs i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .alu_out      (alu_out),
        .new_pc       (new_pc),
        .store_data   (store_data),
        .branch_taken (branch_taken),
        .rd           (rd),
        .funct3       (funct3),
        .iclass       (iclass),
        .rob_idx      (rob_idx),
        .dcache_stall (stall),
        .exm          (exm.stage)
    );

    mem_stage i_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .exm            (exm.mem),
        .dcache_stall   (stall),
        .complete       (complete),
        .complete_idx   (complete_idx),
        .complete_value (complete_value),
        .complete_pc    (complete_pc),
        .complete_taken (complete_taken),
        .complete_exc   (complete_exc)
    );

endmodule

`default_nettype wire

// ==== testbench/ex_mem_props.sv ====
`default_nettype none

`include "cpu_settings.svh"

module ex_mem_props (
    input wire                               clk,
    input wire                               rst_n,
    input wire                               issue_valid,
    input wire cpu_types_pkg::word_t         op_a,
    input wire cpu_types_pkg::word_t         op_b,
    input wire cpu_types_pkg::word_t         pc,
    input wire cpu_types_pkg::word_t         imm,
    input wire cpu_types_pkg::word_t         store_data,
    input wire cpu_types_pkg::funct3_t       funct3,
    input wire                               alt_op,
    input wire cpu_types_pkg::instr_class_t  iclass,
    input wire cpu_types_pkg::reg_idx_t      rd,
    input wire cpu_types_pkg::rob_idx_t      rob_idx,
    input wire                               stall,
    input wire                               complete,
    input wire mem_ops_pkg::exc_code_t       complete_exc
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] stall_run;

    // Consecutive stall cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_run <= '0;
        end else if (stall) begin
            stall_run <= stall_run + 1'b1;
        end else begin
            stall_run <= '0;
        end
    end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !complete)
        else $error("complete high during reset");

    issue_held: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> $stable({issue_valid, op_a, op_b, pc, imm, store_data,
                           funct3, alt_op, iclass, rd, rob_idx}))
        else $error("issue inputs changed while stall was high");

    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        stall_run <= 8'(`REFILL_CYCLES))
        else $error("stall lasted longer than the refill delay");

    exc_with_complete: assert property (@(posedge clk) disable iff (!rst_n)
        (complete_exc != mem_ops_pkg::EXC_NONE) |-> complete)
        else $error("exception code without a completion");

endmodule

bind ex_mem_top ex_mem_props i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .op_a         (op_a),
    .op_b         (op_b),
    .pc           (pc),
    .imm          (imm),
    .store_data   (store_data),
    .funct3       (funct3),
    .alt_op       (alt_op),
    .iclass       (iclass),
    .rd           (rd),
    .rob_idx      (rob_idx),
    .stall        (stall),
    .complete     (complete),
    .complete_exc (complete_exc)
);

`default_nettype wire

// ==== testbench/ex_mem_tb.sv ====
`default_nettype none

`include "cpu_settings.svh"

module ex_mem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 16;
    localparam int NUM_INSTR  = 600;
    localparam int WAIT_LIMIT = 50;
    localparam int IDX_W      = $clog2(`DMEM_WORDS);
    localparam int LINE_LSB   = 2 + $clog2(`LINE_WORDS);

    typedef struct packed {
        cpu_types_pkg::rob_idx_t  idx;
        cpu_types_pkg::word_t     value;
        cpu_types_pkg::word_t     pc;
        logic                     taken;
        mem_ops_pkg::exc_code_t   exc;
        logic                     stalls;
    } expect_t;

    logic                         clk;
    logic                         rst_n;
    logic                         issue_valid;
    cpu_types_pkg::word_t         op_a;
    cpu_types_pkg::word_t         op_b;
    cpu_types_pkg::word_t         pc;
    cpu_types_pkg::word_t         imm;
    cpu_types_pkg::word_t         store_data;
    cpu_types_pkg::funct3_t       funct3;
    logic                         alt_op;
    cpu_types_pkg::instr_class_t  iclass;
    cpu_types_pkg::reg_idx_t      rd;
    cpu_types_pkg::rob_idx_t      rob_idx;

    wire                          stall;
    wire                          complete;
    cpu_types_pkg::rob_idx_t      complete_idx;
    cpu_types_pkg::word_t         complete_value;
    cpu_types_pkg::word_t         complete_pc;
    wire                          complete_taken;
    mem_ops_pkg::exc_code_t       complete_exc;

    // Reference state
    cpu_types_pkg::word_t         mem_model [`DMEM_WORDS];
    expect_t                      exp_q [$];
    expect_t                      mon_exp;
    logic                         tag_valid;
    cpu_types_pkg::word_t         tag_line;
    logic                         stall_seen;
    logic                         timed_out;
    cpu_types_pkg::rob_idx_t      next_rob;
    int                           errors;
    int                           checks;

    ex_mem_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .op_a           (op_a),
        .op_b           (op_b),
        .pc             (pc),
        .imm            (imm),
        .store_data     (store_data),
        .funct3         (funct3),
        .alt_op         (alt_op),
        .iclass         (iclass),
        .rd             (rd),
        .rob_idx        (rob_idx),
        .stall          (stall),
        .complete       (complete),
        .complete_idx   (complete_idx),
        .complete_value (complete_value),
        .complete_pc    (complete_pc),
        .complete_taken (complete_taken),
        .complete_exc   (complete_exc)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    task automatic check_word(input string name, input cpu_types_pkg::word_t got,
                              input cpu_types_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input cpu_types_pkg::rob_idx_t got,
                             input cpu_types_pkg::rob_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_exc(input string name, input mem_ops_pkg::exc_code_t got,
                             input mem_ops_pkg::exc_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, outstanding %0d", checks, errors, exp_q.size());
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string msg);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t: %s", $time, msg);
    endtask

    // RV32I register operations
    function automatic cpu_types_pkg::word_t alu_ref(cpu_types_pkg::word_t a,
            cpu_types_pkg::word_t b, cpu_types_pkg::funct3_t f, logic alt);
        case (f)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? cpu_types_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(cpu_types_pkg::word_t a, cpu_types_pkg::word_t b,
                                        cpu_types_pkg::funct3_t f);
        case (f)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic mem_ops_pkg::exc_code_t exc_ref(logic is_load,
            cpu_types_pkg::funct3_t f, cpu_types_pkg::word_t addr);
        logic mis;
        logic oor;
        case (f[1:0])
            2'b00:   mis = 1'b0;
            2'b01:   mis = addr[0];
            default: mis = (addr[1:0] != 2'b00);
        endcase
        oor = (addr >> 2) >= cpu_types_pkg::word_t'(`DMEM_WORDS);
        if (mis) begin
            return is_load ? mem_ops_pkg::EXC_LOAD_MISALIGNED : mem_ops_pkg::EXC_STORE_MISALIGNED;
        end else if (oor) begin
            return is_load ? mem_ops_pkg::EXC_LOAD_FAULT : mem_ops_pkg::EXC_STORE_FAULT;
        end
        return mem_ops_pkg::EXC_NONE;
    endfunction

    function automatic cpu_types_pkg::word_t load_ref(cpu_types_pkg::word_t w,
            logic [1:0] off, cpu_types_pkg::funct3_t f);
        cpu_types_pkg::word_t s;
        s = w >> (int'(off) * 8);
        case (f)
            3'd0:    return {{24{s[7]}}, s[7:0]};
            3'd1:    return {{16{s[15]}}, s[15:0]};
            3'd4:    return {24'd0, s[7:0]};
            3'd5:    return {16'd0, s[15:0]};
            default: return s;
        endcase
    endfunction

    task automatic write_model(input cpu_types_pkg::word_t addr,
                               input cpu_types_pkg::word_t data, input cpu_types_pkg::funct3_t f);
        int n;
        int base;
        n = (f[1:0] == 2'b00) ? 1 : (f[1:0] == 2'b01) ? 2 : 4;
        base = int'(addr[1:0]);
        for (int b = 0; b < n; b++) begin
            mem_model[addr[2 +: IDX_W]][(base + b) * 8 +: 8] = data[b * 8 +: 8];
        end
    endtask

    // Mostly a few lines near zero, some misaligned, some past the RAM
    function automatic cpu_types_pkg::word_t pick_addr(cpu_types_pkg::funct3_t f);
        int r;
        cpu_types_pkg::word_t a;
        r = int'($urandom % 100);
        a = cpu_types_pkg::word_t'(($urandom % 4) * `LINE_WORDS * 4
                                   + $urandom % (`LINE_WORDS * 4));
        if (r < 85 || r >= 93) begin
            a = a & ~cpu_types_pkg::word_t'((1 << f[1:0]) - 1);
        end
        if (r >= 93) begin
            a = a + cpu_types_pkg::word_t'(`DMEM_WORDS * 4);
        end
        return a;
    endfunction

    task automatic make_instr();
        int r;
        cpu_types_pkg::word_t addr;
        r = int'($urandom % 100);
        op_a       = $urandom;
        op_b       = $urandom;
        pc         = $urandom & ~cpu_types_pkg::word_t'(3);
        imm        = cpu_types_pkg::word_t'(int'($urandom % 128) - 64);
        store_data = $urandom;
        rd         = cpu_types_pkg::reg_idx_t'($urandom);
        alt_op     = 1'($urandom);
        funct3     = cpu_types_pkg::funct3_t'($urandom);
        if (r < 35) begin
            iclass = cpu_types_pkg::ALU;
        end else if (r < 75) begin
            if (r < 55) begin
                iclass = cpu_types_pkg::LOAD;
                case ($urandom % 5)
                    0:       funct3 = 3'd0;
                    1:       funct3 = 3'd1;
                    2:       funct3 = 3'd2;
                    3:       funct3 = 3'd4;
                    default: funct3 = 3'd5;
                endcase
            end else begin
                iclass = cpu_types_pkg::STORE;
                funct3 = cpu_types_pkg::funct3_t'($urandom % 3);
            end
            addr = pick_addr(funct3);
            op_a = addr - imm;
        end else if (r < 90) begin
            iclass = cpu_types_pkg::BRANCH;
            while (funct3 == 3'd2 || funct3 == 3'd3) begin
                funct3 = cpu_types_pkg::funct3_t'($urandom);
            end
            imm = imm & ~cpu_types_pkg::word_t'(1);
            if ($urandom % 4 == 0) begin
                op_b = op_a;
            end
        end else begin
            iclass = cpu_types_pkg::JUMP;
        end
        rob_idx  = next_rob;
        next_rob = next_rob + 1'b1;
    endtask

    task automatic predict();
        expect_t e;
        cpu_types_pkg::word_t addr;
        cpu_types_pkg::word_t line;
        e.idx    = rob_idx;
        e.value  = '0;
        e.pc     = pc + 32'd4;
        e.taken  = 1'b0;
        e.exc    = mem_ops_pkg::EXC_NONE;
        e.stalls = 1'b0;
        addr     = op_a + imm;
        case (iclass)
            cpu_types_pkg::ALU: e.value = alu_ref(op_a, op_b, funct3, alt_op);
            cpu_types_pkg::BRANCH: begin
                e.taken = branch_ref(op_a, op_b, funct3);
                if (e.taken) begin
                    e.pc = pc + imm;
                end
            end
            cpu_types_pkg::JUMP: begin
                e.value = pc + 32'd4;
                e.taken = 1'b1;
                e.pc    = addr & ~cpu_types_pkg::word_t'(1);
            end
            default: begin
                e.exc = exc_ref(iclass == cpu_types_pkg::LOAD, funct3, addr);
                if (e.exc == mem_ops_pkg::EXC_NONE) begin
                    line      = addr >> LINE_LSB;
                    e.stalls  = !tag_valid || (line != tag_line);
                    tag_valid = 1'b1;
                    tag_line  = line;
                    if (iclass == cpu_types_pkg::LOAD) begin
                        e.value = load_ref(mem_model[addr[2 +: IDX_W]], addr[1:0], funct3);
                    end else begin
                        e.value = addr;
                        write_model(addr, store_data, funct3);
                    end
                end
            end
        endcase
        exp_q.push_back(e);
    endtask

    task automatic wait_no_stall();
        int n;
        n = 0;
        while (!timed_out && stall && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!timed_out && stall) begin
            report_timeout("stall stayed high past the wait limit");
        end
    endtask

    // Completions checked mid-cycle against the head of the queue
    always @(negedge clk) begin
        if (rst_n) begin
            if (complete) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("completion for rob slot %0d arrived with none outstanding",
                             complete_idx);
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_idx("complete_idx", complete_idx, mon_exp.idx);
                    check_word("complete_value", complete_value, mon_exp.value);
                    check_word("complete_pc", complete_pc, mon_exp.pc);
                    check_bit("complete_taken", complete_taken, mon_exp.taken);
                    check_exc("complete_exc", complete_exc, mon_exp.exc);
                    check_bit("stall before completion", stall_seen, mon_exp.stalls);
                end
                stall_seen = 1'b0;
            end
            if (stall) begin
                stall_seen = 1'b1;
            end
        end
    end

    initial begin
        int gap;
        int n;
        void'($urandom(83));
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        op_a        = '0;
        op_b        = '0;
        pc          = '0;
        imm         = '0;
        store_data  = '0;
        funct3      = '0;
        alt_op      = 1'b0;
        iclass      = cpu_types_pkg::ALU;
        rd          = '0;
        rob_idx     = '0;
        next_rob    = '0;
        tag_valid   = 1'b0;
        tag_line    = '0;
        stall_seen  = 1'b0;
        timed_out   = 1'b0;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem_model[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_bit("stall", stall, 1'b0);
        check_bit("complete", complete, 1'b0);

        for (int i = 0; i < NUM_INSTR && !timed_out; i++) begin
            gap = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
            for (int g = 0; g < gap && !timed_out; g++) begin
                wait_no_stall();
                issue_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            wait_no_stall();
            if (!timed_out) begin
                make_instr();
                issue_valid = 1'b1;
                predict();
                @(posedge clk);
                #2;
            end
        end
        wait_no_stall();
        issue_valid = 1'b0;

        // Drain
        n = 0;
        while (!timed_out && exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!timed_out && exp_q.size() != 0) begin
            report_timeout("completions still missing after the stream ended");
        end
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/cpu_types_pkg.sv
logic/mem_ops_pkg.sv
logic/ex_mem_if.sv
logic/exec_alu.sv
logic/ex_mem_regs.sv
logic/mem_stage.sv
logic/ex_mem_top.sv
testbench/ex_mem_props.sv
testbench/ex_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ex_mem_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST  := sources.f
SOURCES   := $(shell grep -v '^+' $(FILELIST)) logic/cpu_settings.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "no verdict in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
